// ==== src/prng_pkg.sv ====
package prng_pkg;

  //////////////////////////////
  // Widths with a meaning
  //////////////////////////////

  // One random word or one seed component
  typedef logic [31:0] word_t;
  // Register byte address
  typedef logic [4:0]  addr_t;
  // FIFO fill count, enough for depths up to 16
  typedef logic [4:0]  count_t;
  // AXI response code
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Bit 0 enable, bit 1 reseed request (self-clearing)
  localparam addr_t ADDR_CTRL   = 5'h00;
  // Bits 4:0 fill count, bit 8 running
  localparam addr_t ADDR_STATUS = 5'h04;
  // Read pops one word
  localparam addr_t ADDR_RAND   = 5'h08;
  localparam addr_t ADDR_SEED0  = 5'h10;
  localparam addr_t ADDR_SEED1  = 5'h14;
  localparam addr_t ADDR_SEED2  = 5'h18;
  localparam addr_t ADDR_SEED3  = 5'h1C;

  localparam word_t DEFAULT_SEED = 32'd987654321;

  // Seed set from register block to core
  typedef struct packed {
    word_t s1;
    word_t s2;
    word_t s3;
    word_t s4;
  } seed_set_t;

  // Reseed is a one-cycle pulse
  typedef struct packed {
    logic enable;
    logic reseed;
  } rng_ctrl_t;

  typedef enum logic {
    CORE_IDLE,
    CORE_RUN
  } core_state_t;

endpackage

// ==== src/axil_prng_regs.sv ====
`timescale 1ns/1ps

module axil_prng_regs import prng_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // Write address and data
  input  logic      awvalid,
  output logic      awready,
  input  addr_t     awaddr,
  input  logic      wvalid,
  output logic      wready,
  input  word_t     wdata,
  input  logic [3:0] wstrb,
  // Write response
  output logic      bvalid,
  input  logic      bready,
  output axi_resp_t bresp,
  // Read address and data
  input  logic      arvalid,
  output logic      arready,
  input  addr_t     araddr,
  output logic      rvalid,
  input  logic      rready,
  output word_t     rdata,
  output axi_resp_t rresp,
  // FIFO side
  input  word_t     head,
  input  logic      empty,
  input  count_t    count,
  output logic      pop,
  // Core side
  output rng_ctrl_t ctrl,
  output seed_set_t seeds
);

  rng_ctrl_t ctrl_q;
  seed_set_t seed_q;
  logic      wr_hs;
  logic      ar_hs;
  word_t     rd_data_c;
  axi_resp_t rd_resp_c;

  assign wr_hs = awvalid && awready && wvalid && wready;
  assign ar_hs = arvalid && arready;

  assign ctrl  = ctrl_q;
  assign seeds = seed_q;

  // Pop in the cycle the RAND address is taken
  assign pop = ar_hs && (araddr == ADDR_RAND) && !empty;

  //////////////////////////////
  // Write channel
  //////////////////////////////

  // Strobes are not looked at, every write is a full word
  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      ctrl_q  <= '0;
      seed_q  <= '{DEFAULT_SEED, DEFAULT_SEED, DEFAULT_SEED, DEFAULT_SEED};
    end else begin
      // Accept both channels together for a single cycle
      awready <= awvalid && wvalid && !bvalid && !awready;
      wready  <= awvalid && wvalid && !bvalid && !awready;
      ctrl_q.reseed <= 1'b0;

      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp  <= RESP_OKAY;
        case (awaddr)
          ADDR_CTRL: begin
            ctrl_q.enable <= wdata[0];
            ctrl_q.reseed <= wdata[1];
          end
          ADDR_SEED0: seed_q.s1 <= wdata;
          ADDR_SEED1: seed_q.s2 <= wdata;
          ADDR_SEED2: seed_q.s3 <= wdata;
          ADDR_SEED3: seed_q.s4 <= wdata;
          // Read-only registers, write dropped
          ADDR_STATUS, ADDR_RAND: ;
          default: bresp <= RESP_SLVERR;
        endcase
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////

  always_comb begin
    rd_data_c = '0;
    rd_resp_c = RESP_OKAY;
    case (araddr)
      ADDR_CTRL:   rd_data_c[0] = ctrl_q.enable;
      ADDR_STATUS: begin
        rd_data_c[4:0] = count;
        rd_data_c[8]   = ctrl_q.enable;
      end
      ADDR_RAND: begin
        if (!empty) begin
          rd_data_c = head;
        end else begin
          rd_resp_c = RESP_SLVERR;
        end
      end
      ADDR_SEED0:  rd_data_c = seed_q.s1;
      ADDR_SEED1:  rd_data_c = seed_q.s2;
      ADDR_SEED2:  rd_data_c = seed_q.s3;
      ADDR_SEED3:  rd_data_c = seed_q.s4;
      default:     rd_resp_c = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      // No new address while a response is pending
      arready <= arvalid && !rvalid && !arready;
      if (ar_hs) begin
        rvalid <= 1'b1;
        rdata  <= rd_data_c;
        rresp  <= rd_resp_c;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Response and its data held until the master takes them
  assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  // A popped word has to exist in the FIFO
  assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== src/lfsr113_core.sv ====
`timescale 1ns/1ps

module lfsr113_core import prng_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  rng_ctrl_t ctrl,
  input  seed_set_t seeds,
  input  logic      full,
  output logic      push,
  output word_t     push_data
);

  core_state_t state;
  core_state_t state_next;
  word_t       z1, z2, z3, z4;

  // One Tausworthe component step of shift, mask and xor
  function automatic word_t taus_step(input word_t z, input word_t mask,
                                      input int unsigned q, input int unsigned s,
                                      input int unsigned k);
    word_t mixed;
    mixed = ((z << q) ^ z) >> s;
    return ((z & mask) << k) ^ mixed;
  endfunction

  //////////////////////////////
  // Run control
  //////////////////////////////

  // Running follows enable from either state
  always_comb begin
    state_next = ctrl.enable ? CORE_RUN : CORE_IDLE;
  end

  // Emit the current xor and step together unless a reseed is loading
  assign push      = (state == CORE_RUN) && ctrl.enable && !ctrl.reseed && !full;
  assign push_data = z1 ^ z2 ^ z3 ^ z4;

  //////////////////////////////
  // Generator state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CORE_IDLE;
      z1    <= DEFAULT_SEED;
      z2    <= DEFAULT_SEED;
      z3    <= DEFAULT_SEED;
      z4    <= DEFAULT_SEED;
    end else begin
      state <= state_next;
      if (ctrl.reseed) begin
        z1 <= seeds.s1;
        z2 <= seeds.s2;
        z3 <= seeds.s3;
        z4 <= seeds.s4;
      end else if (push) begin
        z1 <= taus_step(z1, 32'hFFFF_FFFE, 6, 13, 18);
        z2 <= taus_step(z2, 32'hFFFF_FFF8, 2, 27, 2);
        z3 <= taus_step(z3, 32'hFFFF_FFF0, 13, 21, 7);
        z4 <= taus_step(z4, 32'hFFFF_FF80, 3, 12, 13);
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

// ==== src/rand_fifo.sv ====
`timescale 1ns/1ps

module rand_fifo import prng_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   push,
  input  word_t  push_data,
  input  logic   pop,
  output word_t  head,
  output logic   empty,
  output logic   full,
  output count_t count
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Depth must wrap the pointers cleanly and fit the count
  if ((FIFO_DEPTH < 2) || (FIFO_DEPTH > 16) || ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)) begin
    $error("FIFO_DEPTH must be a power of two from 2 to 16");
  end

  word_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic              do_push;
  logic              do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == count_t'(FIFO_DEPTH));

  // Storage, no reset
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) count <= count_t'(FIFO_DEPTH));

endmodule

// ==== src/prng_top.sv ====
`timescale 1ns/1ps

module prng_top import prng_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       awvalid,
  output logic       awready,
  input  addr_t      awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  word_t      wdata,
  input  logic [3:0] wstrb,
  output logic       bvalid,
  input  logic       bready,
  output axi_resp_t  bresp,
  input  logic       arvalid,
  output logic       arready,
  input  addr_t      araddr,
  output logic       rvalid,
  input  logic       rready,
  output word_t      rdata,
  output axi_resp_t  rresp
);

  localparam int FIFO_DEPTH = 8;

  rng_ctrl_t ctrl;
  seed_set_t seeds;
  logic      push, pop, empty, full;
  word_t     push_data, head;
  count_t    count;

  axil_prng_regs u_regs (
    .clk, .reset, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
    .rdata, .rresp, .head, .empty, .count, .pop, .ctrl, .seeds
  );

  lfsr113_core u_core (
    .clk, .reset, .ctrl, .seeds, .full, .push, .push_data
  );

  rand_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .reset, .push, .push_data, .pop, .head, .empty, .full, .count
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset held over the first rising edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== testbench/tb_prng_top.sv ====
`timescale 1ns/1ps

module tb_prng_top import prng_pkg::*; ();

  localparam int FIFO_DEPTH = 8;
  // About 200 transfers of at most 15 cycles each, plus polls and the stall wait
  localparam int MAX_CYCLES = 20000;

  logic       clk;
  logic       reset;
  logic       awvalid;
  logic       awready;
  addr_t      awaddr;
  logic       wvalid;
  logic       wready;
  word_t      wdata;
  logic [3:0] wstrb;
  logic       bvalid;
  logic       bready;
  axi_resp_t  bresp;
  logic       arvalid;
  logic       arready;
  addr_t      araddr;
  logic       rvalid;
  logic       rready;
  word_t      rdata;
  axi_resp_t  rresp;

  seed_set_t  model_state;
  word_t      expected_q[$];
  addr_t      read_addr_q[$];
  addr_t      done_addr;
  int         error_count;
  int         tests_run;
  int         tests_failed;
  int         test_start_errors;
  int         cycle_count;

  tb_clock_gen clock_gen (.clk, .reset);

  prng_top DUT (.*);

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // LFSR113 recurrence, one step of all four components
  function automatic seed_set_t lfsr113_step(input seed_set_t s);
    seed_set_t n;
    word_t     b;
    b    = ((s.s1 << 6) ^ s.s1) >> 13;
    n.s1 = ((s.s1 & 32'hFFFF_FFFE) << 18) ^ b;
    b    = ((s.s2 << 2) ^ s.s2) >> 27;
    n.s2 = ((s.s2 & 32'hFFFF_FFF8) << 2) ^ b;
    b    = ((s.s3 << 13) ^ s.s3) >> 21;
    n.s3 = ((s.s3 & 32'hFFFF_FFF0) << 7) ^ b;
    b    = ((s.s4 << 3) ^ s.s4) >> 12;
    n.s4 = ((s.s4 & 32'hFFFF_FF80) << 13) ^ b;
    return n;
  endfunction

  task automatic expect_words(input int n);
    repeat (n) begin
      expected_q.push_back(model_state.s1 ^ model_state.s2 ^ model_state.s3 ^ model_state.s4);
      model_state = lfsr113_step(model_state);
    end
  endtask

  // Minimum bit set in each component keeps it legal
  function automatic seed_set_t random_seeds();
    seed_set_t s;
    s.s1 = $urandom() | 32'd2;
    s.s2 = $urandom() | 32'd8;
    s.s3 = $urandom() | 32'd16;
    s.s4 = $urandom() | 32'd128;
    return s;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s: got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
    end
  endtask

  task automatic check_resp(input axi_resp_t actual, input axi_resp_t expected,
                            input string what);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s: response %0d, expected %0d",
               $time, what, actual, expected);
    end
  endtask

  //////////////////////////////
  // AXI4-Lite master
  //////////////////////////////

  task automatic axil_write(input addr_t addr, input word_t data, output axi_resp_t resp);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    do @(negedge clk); while (!(awready && wready));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(negedge clk); while (!bvalid);
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  // rready stays low for pause cycles once rvalid is up
  task automatic axil_read(input addr_t addr, input int pause, output word_t data,
                           output axi_resp_t resp);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    repeat (pause) @(negedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input word_t data);
    axi_resp_t resp;
    axil_write(addr, data, resp);
    check_resp(resp, RESP_OKAY, $sformatf("write to 0x%02h", addr));
  endtask

  task automatic check_reg(input addr_t addr, input word_t expected, input axi_resp_t exp_resp);
    word_t     data;
    axi_resp_t resp;
    axil_read(addr, 0, data, resp);
    check_resp(resp, exp_resp, $sformatf("read of 0x%02h", addr));
    check_word(data, expected, $sformatf("read of 0x%02h", addr));
  endtask

  // Data of popped words is checked by the compare process
  task automatic read_rand(input int pause);
    word_t     data;
    axi_resp_t resp;
    axil_read(ADDR_RAND, pause, data, resp);
    check_resp(resp, RESP_OKAY, "RAND read");
  endtask

  task automatic read_status(output word_t status);
    axi_resp_t resp;
    axil_read(ADDR_STATUS, 0, status, resp);
    check_resp(resp, RESP_OKAY, "STATUS read");
  endtask

  task automatic drain_fifo();
    word_t status;
    read_status(status);
    expect_words(int'(status[4:0]));
    repeat (int'(status[4:0])) read_rand(0);
  endtask

  task automatic load_seeds(input seed_set_t s);
    write_reg(ADDR_SEED0, s.s1);
    write_reg(ADDR_SEED1, s.s2);
    write_reg(ADDR_SEED2, s.s3);
    write_reg(ADDR_SEED3, s.s4);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (expected_q.size() != 0) begin
      error_count++;
      $display("%0d expected words were never read back", expected_q.size());
      expected_q.delete();
    end
    if (error_count == test_start_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  // Handshakes seen here complete on the next rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (arvalid && arready) begin
        read_addr_q.push_back(araddr);
      end
      if (rvalid && rready) begin
        if (read_addr_q.size() == 0) begin
          error_count++;
          $display("A read response came back without an accepted read address");
        end else begin
          done_addr = read_addr_q.pop_front();
          if (done_addr == ADDR_RAND && rresp == RESP_OKAY) begin
            if (expected_q.size() == 0) begin
              error_count++;
              $display("A random word came back with no expected word left");
            end else begin
              check_word(rdata, expected_q.pop_front(), "random word");
            end
          end
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    seed_set_t seeds;
    word_t     status;
    axi_resp_t resp;
    void'($urandom(32'h1e2d29f3));
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = 4'h0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    error_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_start_errors = 0;
    wait (reset == 1'b0);

    model_state = '{DEFAULT_SEED, DEFAULT_SEED, DEFAULT_SEED, DEFAULT_SEED};
    write_reg(ADDR_CTRL, 32'h1);
    expect_words(20);
    repeat (20) read_rand(0);
    end_test("default seeds");

    // Stop and drain first, so no old words sit ahead of the new sequence
    write_reg(ADDR_CTRL, 32'h0);
    drain_fifo();
    seeds = random_seeds();
    load_seeds(seeds);
    write_reg(ADDR_CTRL, 32'h3);
    model_state = seeds;
    expect_words(30);
    repeat (30) read_rand(0);
    end_test("reseed");

    do read_status(status); while (status[4:0] != 5'(FIFO_DEPTH));
    repeat (50) @(posedge clk);
    read_status(status);
    check_word(status, 32'h100 | FIFO_DEPTH, "STATUS while stalled");
    expect_words(12);
    repeat (12) read_rand(0);
    end_test("back-pressure");

    write_reg(ADDR_CTRL, 32'h0);
    drain_fifo();
    check_reg(ADDR_RAND, 32'h0, RESP_SLVERR);
    check_reg(ADDR_STATUS, 32'h0, RESP_OKAY);
    end_test("stop");

    seeds = random_seeds();
    load_seeds(seeds);
    check_reg(ADDR_SEED0, seeds.s1, RESP_OKAY);
    check_reg(ADDR_SEED1, seeds.s2, RESP_OKAY);
    check_reg(ADDR_SEED2, seeds.s3, RESP_OKAY);
    check_reg(ADDR_SEED3, seeds.s4, RESP_OKAY);
    write_reg(ADDR_CTRL, 32'h3);
    model_state = seeds;
    // Reseed bit clears itself
    check_reg(ADDR_CTRL, 32'h1, RESP_OKAY);
    check_reg(5'h0C, 32'h0, RESP_SLVERR);
    axil_write(5'h0C, $urandom(), resp);
    check_resp(resp, RESP_SLVERR, "write to 0x0c");
    end_test("registers and errors");

    expect_words(40);
    repeat (40) read_rand(int'($urandom() % 6));
    end_test("random read pauses");

    $display("%0d tests run, %0d tests with errors, %0d errors in total",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
src/prng_pkg.sv
src/axil_prng_regs.sv
src/lfsr113_core.sv
src/rand_fifo.sv
src/prng_top.sv
testbench/tb_clock_gen.sv
testbench/tb_prng_top.sv

// ==== Makefile ====
TOP := tb_prng_top

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing -sv -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir -o sim_prng

run: compile
	./obj_dir/sim_prng | tee sim.log

# The log decides the result, the simulator exit code does not
check: run
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
